/* include/bexkat_config.svh */
`ifndef BEXKAT_CONFIG_SVH
`define BEXKAT_CONFIG_SVH

// core data path width in bits
`define BEXKAT_DATA_WIDTH 32

// general purpose registers, r0 reads as zero
`define BEXKAT_REG_COUNT 16

// first fetch address
`define BEXKAT_RESET_PC 32'h0000_0000

`endif

/* hdl/isa_pkg.sv */
package isa_pkg;

  localparam int OPCODE_W  = 4;
  localparam int FUNC_W    = 3;
  localparam int REG_IDX_W = 4;
  localparam int IMM_W     = 16;
  localparam int INSTR_W   = 32;
  localparam int RC_LSB    = 12; // rc sits in the top nibble of imm16

  typedef enum logic [OPCODE_W-1:0] {
    op_alu_rr  = 4'h0,
    op_alu_imm = 4'h1,
    op_ldi     = 4'h2,
    op_mul     = 4'h3,
    op_mulh    = 4'h4,
    op_ldw     = 4'h5,
    op_stw     = 4'h6,
    op_ldb     = 4'h7,
    op_stb     = 4'h8,
    op_bra     = 4'h9,
    op_beq     = 4'ha,
    op_halt    = 4'hf
  } opcode_t;

  typedef struct packed {
    opcode_t               opcode; // 31:28
    logic [FUNC_W-1:0]     func;   // 27:25
    logic                  spare;  // 24
    logic [REG_IDX_W-1:0]  ra;     // 23:20
    logic [REG_IDX_W-1:0]  rb;     // 19:16
    logic [IMM_W-1:0]      imm16;  // 15:0, also holds rc
  } instr_t;

  function automatic logic [REG_IDX_W-1:0] instr_rc(instr_t i);
    return i.imm16[RC_LSB +: REG_IDX_W];
  endfunction

  function automatic logic [INSTR_W-1:0] imm_sext(instr_t i);
    return {{(INSTR_W-IMM_W){i.imm16[IMM_W-1]}}, i.imm16};
  endfunction

endpackage

/* hdl/datapath_pkg.sv */
`include "bexkat_config.svh"

package datapath_pkg;

  typedef logic [`BEXKAT_DATA_WIDTH-1:0] word_t;
  typedef logic [$clog2(`BEXKAT_REG_COUNT)-1:0] reg_idx_t;
  typedef logic [`BEXKAT_DATA_WIDTH/8-1:0] lanes_t; // one bit per byte lane

  typedef enum logic [2:0] {
    add, sub, and_op, or_op, xor_op, shl, shr, asr
  } alu_func_t;

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } ccr_t;

  typedef enum logic [1:0] {pc_hold, pc_plus4, pc_branch} pc_sel_t;

  typedef enum logic [1:0] {mdr_hold, mdr_bus, mdr_reg_b} mdr_sel_t;

  // register write data source
  typedef enum logic [2:0] {wb_alu, wb_mul_lo, wb_mul_hi, wb_mdr, wb_imm} wb_sel_t;

  typedef enum logic {alu2_reg, alu2_imm} alu2_sel_t;

  typedef enum logic {addr_pc, addr_mar} addr_sel_t;

endpackage

/* hdl/alu.sv */
module alu import datapath_pkg::*; (
  input  word_t     in1,
  input  word_t     in2,
  input  alu_func_t func,
  output word_t     result,
  output ccr_t      flags
);

  localparam int W  = $bits(word_t);
  localparam int SH = $clog2(W);

  logic [W:0]    sum;
  logic [W:0]    diff; // top bit is the borrow
  logic [SH-1:0] shamt;

  assign sum   = {1'b0, in1} + {1'b0, in2};
  assign diff  = {1'b0, in1} - {1'b0, in2};
  assign shamt = in2[SH-1:0];

  always_comb begin
    result         = sum[W-1:0];
    flags.carry    = 1'b0;
    flags.overflow = 1'b0;
    case (func)
      add: begin
        result         = sum[W-1:0];
        flags.carry    = sum[W];
        flags.overflow = (in1[W-1] == in2[W-1]) && (sum[W-1] != in1[W-1]);
      end
      sub: begin
        result         = diff[W-1:0];
        flags.carry    = diff[W];
        flags.overflow = (in1[W-1] != in2[W-1]) && (diff[W-1] != in1[W-1]);
      end
      and_op: result = in1 & in2;
      or_op:  result = in1 | in2;
      xor_op: result = in1 ^ in2;
      shl:    result = in1 << shamt;
      shr:    result = in1 >> shamt;
      asr:    result = word_t'($signed(in1) >>> shamt);
      default: result = sum[W-1:0];
    endcase
    flags.negative = result[W-1];
    flags.zero     = (result == '0);
  end

endmodule

/* hdl/intcalc.sv */
module intcalc import datapath_pkg::*; (
  input  logic                       clk,
  input  logic                       reset_n,
  input  word_t                      in1,
  input  word_t                      in2,
  output logic [2*$bits(word_t)-1:0] product
);

  localparam int W = $bits(word_t);

  logic signed [2*W-1:0] full;

  // operands widen with sign before the multiply
  assign full = $signed(in1) * $signed(in2);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      product <= '0;
    end else begin
      product <= full; // sampled every cycle, control waits one state
    end
  end

endmodule

/* hdl/register_file.sv */
`include "bexkat_config.svh"

module register_file import datapath_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  reg_idx_t read_addr1,
  input  reg_idx_t read_addr2,
  input  reg_idx_t write_addr,
  input  word_t    write_data,
  input  logic     write_en,
  output word_t    data1,
  output word_t    data2
);

  word_t regs [`BEXKAT_REG_COUNT];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < `BEXKAT_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && write_addr != '0) begin
      regs[write_addr] <= write_data;
    end
  end

  // r0 is never written so it keeps its reset zero
  assign data1 = regs[read_addr1];
  assign data2 = regs[read_addr2];

  a_write_addr_known: assert property (@(posedge clk) disable iff (!reset_n)
    write_en |-> !$isunknown(write_addr));

endmodule

/* hdl/control.sv */
module control import isa_pkg::*, datapath_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  instr_t     ir,
  input  ccr_t       ccr,
  input  logic       waitrequest,
  input  logic [1:0] addr_low,
  output pc_sel_t    pc_sel,
  output mdr_sel_t   mdr_sel,
  output wb_sel_t    wb_sel,
  output alu2_sel_t  alu2_sel,
  output addr_sel_t  addr_sel,
  output alu_func_t  alu_func,
  output reg_idx_t   read_addr1,
  output reg_idx_t   read_addr2,
  output reg_idx_t   write_addr,
  output logic       reg_write,
  output logic       ir_write,
  output logic       ccr_write,
  output logic       mar_write,
  output logic       read,
  output logic       write,
  output lanes_t     byteenable,
  output logic       halted
);

  typedef enum logic [2:0] {
    st_fetch, st_decode, st_execute, st_mul_wait, st_memory, st_writeback, st_halted
  } state_t;

  state_t state, state_next;
  logic bus_armed; // strobe allowed after the address setup cycle
  logic fetch_en;  // low until the first edge after reset
  logic mem_done;
  logic is_alu, is_mul, is_load, is_store, is_byte, is_halt;
  logic writes_reg, taken;

  assign is_alu     = ir.opcode inside {op_alu_rr, op_alu_imm};
  assign is_mul     = ir.opcode inside {op_mul, op_mulh};
  assign is_load    = ir.opcode inside {op_ldw, op_ldb};
  assign is_store   = ir.opcode inside {op_stw, op_stb};
  assign is_byte    = ir.opcode inside {op_ldb, op_stb};
  assign is_halt    = ir.opcode == op_halt;
  assign writes_reg = is_alu | is_mul | is_load | (ir.opcode == op_ldi);
  assign taken      = (ir.opcode == op_bra) | ((ir.opcode == op_beq) & ccr.zero);

  assign mem_done = (state == st_memory) && bus_armed && !waitrequest;

  assign read_addr1 = ir.rb;
  assign read_addr2 = is_store ? ir.ra : instr_rc(ir); // store source rides port 2
  assign write_addr = ir.ra;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= st_fetch;
      bus_armed <= 1'b0;
      fetch_en  <= 1'b0;
    end else begin
      state     <= state_next;
      bus_armed <= (state == st_memory) && !mem_done;
      fetch_en  <= 1'b1;
    end
  end

  always_comb begin
    case (ir.opcode)
      op_mul:         wb_sel = wb_mul_lo;
      op_mulh:        wb_sel = wb_mul_hi;
      op_ldw, op_ldb: wb_sel = wb_mdr;
      op_ldi:         wb_sel = wb_imm;
      default:        wb_sel = wb_alu;
    endcase
  end

  always_comb begin
    state_next = state;
    pc_sel     = pc_hold;
    mdr_sel    = mdr_hold;
    addr_sel   = addr_pc;
    alu_func   = is_alu ? alu_func_t'(ir.func) : add; // add forms the effective address
    alu2_sel   = (ir.opcode == op_alu_rr) ? alu2_reg : alu2_imm;
    reg_write  = 1'b0;
    ir_write   = 1'b0;
    ccr_write  = 1'b0;
    mar_write  = 1'b0;
    read       = 1'b0;
    write      = 1'b0;
    byteenable = '1;
    halted     = 1'b0;
    case (state)
      st_fetch: begin
        read = fetch_en;
        if (fetch_en && !waitrequest) begin
          ir_write   = 1'b1;
          pc_sel     = pc_plus4;
          state_next = st_decode;
        end
      end
      st_decode: state_next = st_execute;
      st_execute: begin
        ccr_write = is_alu;
        mar_write = is_load | is_store;
        if (is_store)
          mdr_sel = mdr_reg_b;
        if (taken)
          pc_sel = pc_branch;
        if (is_mul)
          state_next = st_mul_wait; // product lands in the multiplier register
        else if (is_load || is_store)
          state_next = st_memory;
        else
          state_next = st_writeback;
      end
      st_mul_wait: state_next = st_writeback;
      st_memory: begin
        addr_sel = addr_mar;
        if (is_byte)
          byteenable = lanes_t'(1) << addr_low;
        read  = is_load & bus_armed;
        write = is_store & bus_armed;
        if (mem_done) begin
          if (is_load)
            mdr_sel = mdr_bus;
          state_next = st_writeback;
        end
      end
      st_writeback: begin
        reg_write = writes_reg;
        if (is_halt) begin
          halted     = 1'b1;
          state_next = st_halted;
        end else begin
          state_next = st_fetch;
        end
      end
      st_halted: halted = 1'b1; // idle until reset
      default: state_next = st_fetch;
    endcase
  end

  a_one_strobe: assert property (@(posedge clk) disable iff (!reset_n)
    !(read && write));

  // bus request must not change while stalled
  a_stall_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (read || write) && waitrequest |=> $stable({read, write, byteenable}));

  a_byte_lane: assert property (@(posedge clk) disable iff (!reset_n)
    is_byte && (read || write) && (state == st_memory) |-> $onehot(byteenable));

endmodule

/* hdl/bexkat_core.sv */
`include "bexkat_config.svh"

module bexkat_core import isa_pkg::*, datapath_pkg::*; (
  input  logic   clk,
  input  logic   reset_n,
  output word_t  address,
  output logic   read,
  output logic   write,
  output word_t  writedata,
  output lanes_t byteenable,
  input  word_t  readdata,
  input  logic   waitrequest,
  output logic   halted
);

  localparam int W = $bits(word_t);

  word_t  pc, mar, mdr;
  instr_t ir;
  ccr_t   ccr;

  pc_sel_t   pc_sel;
  mdr_sel_t  mdr_sel;
  wb_sel_t   wb_sel;
  alu2_sel_t alu2_sel;
  addr_sel_t addr_sel;
  alu_func_t alu_func;
  reg_idx_t  read_addr1, read_addr2, write_addr;
  logic      reg_write, ir_write, ccr_write, mar_write;

  word_t  reg_data1, reg_data2, reg_wdata;
  word_t  imm_ext, alu_in2, alu_result, load_data;
  ccr_t   alu_flags;
  logic [2*W-1:0] product;
  logic [1:0] lane;
  logic [7:0] lane_byte;

  assign imm_ext = imm_sext(ir);
  assign lane    = mar[1:0];
  assign address = (addr_sel == addr_mar) ? mar : pc;
  assign alu_in2 = (alu2_sel == alu2_reg) ? reg_data2 : imm_ext;

  // byte lane steering
  assign lane_byte = readdata[{lane, 3'b000} +: 8];
  assign load_data = (ir.opcode == op_ldb) ? {{(W-8){lane_byte[7]}}, lane_byte} : readdata;
  assign writedata = (ir.opcode == op_stb) ? (word_t'(mdr[7:0]) << {lane, 3'b000}) : mdr;

  always_comb begin
    case (wb_sel)
      wb_mul_lo: reg_wdata = product[W-1:0];
      wb_mul_hi: reg_wdata = product[2*W-1:W];
      wb_mdr:    reg_wdata = mdr;
      wb_imm:    reg_wdata = imm_ext;
      default:   reg_wdata = alu_result;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc  <= `BEXKAT_RESET_PC;
      ir  <= '0;
      ccr <= '0;
    end else begin
      case (pc_sel)
        pc_plus4:  pc <= pc + word_t'(4);
        pc_branch: pc <= pc + imm_ext; // pc already past the branch
        default:   pc <= pc;
      endcase
      if (ir_write)
        ir <= instr_t'(readdata);
      if (ccr_write)
        ccr <= alu_flags;
    end
  end

  always_ff @(posedge clk) begin
    if (mar_write)
      mar <= alu_result; // effective address
    case (mdr_sel)
      mdr_bus:   mdr <= load_data;
      mdr_reg_b: mdr <= reg_data2;
      default:   mdr <= mdr;
    endcase
  end

  control i_control (
    .clk        (clk),
    .reset_n    (reset_n),
    .ir         (ir),
    .ccr        (ccr),
    .waitrequest(waitrequest),
    .addr_low   (address[1:0]),
    .pc_sel     (pc_sel),
    .mdr_sel    (mdr_sel),
    .wb_sel     (wb_sel),
    .alu2_sel   (alu2_sel),
    .addr_sel   (addr_sel),
    .alu_func   (alu_func),
    .read_addr1 (read_addr1),
    .read_addr2 (read_addr2),
    .write_addr (write_addr),
    .reg_write  (reg_write),
    .ir_write   (ir_write),
    .ccr_write  (ccr_write),
    .mar_write  (mar_write),
    .read       (read),
    .write      (write),
    .byteenable (byteenable),
    .halted     (halted)
  );

  alu i_alu (
    .in1   (reg_data1),
    .in2   (alu_in2),
    .func  (alu_func),
    .result(alu_result),
    .flags (alu_flags)
  );

  intcalc i_intcalc (
    .clk    (clk),
    .reset_n(reset_n),
    .in1    (reg_data1),
    .in2    (reg_data2),
    .product(product)
  );

  register_file i_register_file (
    .clk       (clk),
    .reset_n   (reset_n),
    .read_addr1(read_addr1),
    .read_addr2(read_addr2),
    .write_addr(write_addr),
    .write_data(reg_wdata),
    .write_en  (reg_write),
    .data1     (reg_data1),
    .data2     (reg_data2)
  );

endmodule

/* tests/bexkat_tb.sv */
module bexkat_tb import isa_pkg::*, datapath_pkg::*;;

  localparam int TESTS    = 6;
  localparam int BODY     = 40;
  localparam int PROG_LEN = BODY + 31; // 15 ldi, body, 15 stores, halt
  localparam int LIMIT    = PROG_LEN * (6 + 2 * 3) * TESTS + TESTS * 8 + 2000;

  logic   clk = 1'b0;
  logic   reset_n, read, write, waitrequest, halted;
  word_t  address, writedata, readdata;
  lanes_t byteenable;

  word_t  mem [1024];
  word_t  ref_mem [1024];
  word_t  prog [$];
  word_t  exp_addr [$];
  word_t  exp_data [$];
  lanes_t exp_lanes [$];
  string  test_name;
  int     errors = 0;
  int     failed_tests = 0;
  int     cycles = 0;
  int     wait_left = -1;
  bit     stall_en;

  always #20 clk = ~clk;

  bexkat_core i_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .address    (address),
    .read       (read),
    .write      (write),
    .writedata  (writedata),
    .byteenable (byteenable),
    .readdata   (readdata),
    .waitrequest(waitrequest),
    .halted     (halted)
  );

  task automatic check_word(string what, word_t exp, word_t act);
    if (exp !== act) begin
      $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_lanes(string what, lanes_t exp, lanes_t act);
    if (exp !== act) begin
      $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_halt(string what, bit exp, bit act);
    if (exp !== act) begin
      $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
      errors++;
    end
  endtask

  // memory slave, one random stall count per access
  always @(negedge clk) begin
    if (!reset_n || !(read || write)) begin
      waitrequest = 1'b1;
      wait_left   = -1;
    end else begin
      if (wait_left < 0)
        wait_left = stall_en ? int'($urandom % 4) : 0;
      if (wait_left > 0) begin
        waitrequest = 1'b1;
        wait_left--;
      end else begin
        waitrequest = 1'b0;
        if (address[31:12] != '0) begin
          $display("error %s: bus address %h outside memory", test_name, address);
          errors++;
        end
        if (read) begin
          readdata = mem[address[11:2]];
        end else if (exp_addr.size() == 0) begin
          $display("error %s: bus write to %h that the model does not predict",
                   test_name, address);
          errors++;
        end else begin
          check_word("write address", exp_addr.pop_front(), address);
          check_lanes("write lanes", exp_lanes.pop_front(), byteenable);
          check_word("write data", exp_data.pop_front(), writedata);
        end
        if (write) begin
          for (int b = 0; b < 4; b++) begin
            if (byteenable[b])
              mem[address[11:2]][8*b +: 8] = writedata[8*b +: 8];
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout: the core did not halt within %0d cycles", LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic word_t encode(opcode_t op, logic [2:0] func, reg_idx_t ra,
                                   reg_idx_t rb, logic [15:0] imm);
    instr_t i;
    i.opcode = op;
    i.func   = func;
    i.spare  = 1'b0;
    i.ra     = ra;
    i.rb     = rb;
    i.imm16  = imm;
    return word_t'(i);
  endfunction

  function automatic opcode_t pick_op(int t);
    opcode_t all_ops [11] = '{op_alu_rr, op_alu_imm, op_ldi, op_mul, op_mulh, op_ldw,
                               op_stw, op_ldb, op_stb, op_bra, op_beq};
    opcode_t focus [6][2] = '{'{op_alu_rr, op_alu_imm}, '{op_mul, op_mulh},
                              '{op_stw, op_stb}, '{op_ldb, op_ldw}, '{op_beq, op_alu_rr},
                              '{op_alu_rr, op_ldb}};
    if ($urandom % 10 < 6)
      return focus[t][$urandom % 2];
    return all_ops[$urandom % 11];
  endfunction

  task automatic build_program(int t);
    opcode_t    op;
    logic [2:0] func;
    reg_idx_t   ra, rb, rc;
    logic [15:0] imm;
    int         room;
    prog.delete();
    for (int r = 1; r < 15; r++)
      prog.push_back(encode(op_ldi, 3'd0, reg_idx_t'(r), 4'd0, 16'($urandom)));
    prog.push_back(encode(op_ldi, 3'd0, 4'd15, 4'd0, 16'h0400)); // r15 points at data
    for (int k = 0; k < BODY; k++) begin
      op   = pick_op(t);
      func = 3'($urandom);
      ra   = reg_idx_t'(1 + $urandom % 14);
      rb   = reg_idx_t'($urandom);
      rc   = reg_idx_t'($urandom);
      imm  = 16'($urandom);
      case (op)
        op_alu_rr: begin
          if ($urandom % 4 == 0) begin
            rc   = rb; // forces a zero result for beq
            func = ($urandom % 2) ? 3'(sub) : 3'(xor_op);
          end
          imm = {rc, 12'h000};
        end
        op_alu_imm: if ($urandom % 4 == 0) imm = 16'd31;
        op_mul, op_mulh: imm = {rc, 12'h000};
        op_ldw, op_stw: begin
          rb  = 4'd15;
          imm = 16'($urandom % 256) << 2;
        end
        op_ldb, op_stb: begin
          rb  = 4'd15;
          imm = 16'($urandom % 1024);
        end
        op_bra, op_beq: begin
          room = BODY - 1 - k;
          imm  = (room == 0) ? 16'd0 : 16'(4 * (1 + $urandom % (room < 3 ? room : 3)));
        end
        default: ;
      endcase
      prog.push_back(encode(op, func, ra, rb, imm));
    end
    for (int r = 1; r < 16; r++)
      prog.push_back(encode(op_stw, 3'd0, reg_idx_t'(r), 4'd0, 16'(12'h800 + 4 * r)));
    prog.push_back(encode(op_halt, 3'd0, 4'd0, 4'd0, 16'd0));
  endtask

  // instruction set model, predicts writes and final memory
  task automatic run_model();
    word_t  r [16];
    word_t  pc, a, b, res, imm, ea;
    instr_t i;
    logic   zero;
    logic signed [63:0] prod;
    logic [7:0] byte_val;
    int     steps;
    foreach (r[n]) r[n] = '0;
    pc    = '0;
    zero  = 1'b0;
    steps = 0;
    while (steps < 1000) begin
      i   = instr_t'(ref_mem[pc[11:2]]);
      pc  = pc + 4;
      imm = {{16{i.imm16[15]}}, i.imm16};
      a   = r[i.rb];
      b   = (i.opcode == op_alu_imm) ? imm : r[i.imm16[15:12]];
      ea  = a + imm;
      steps++;
      if (i.opcode == op_halt)
        break;
      case (i.opcode)
        op_alu_rr, op_alu_imm: begin
          case (alu_func_t'(i.func))
            add:     res = a + b;
            sub:     res = a - b;
            and_op:  res = a & b;
            or_op:   res = a | b;
            xor_op:  res = a ^ b;
            shl:     res = a << b[4:0];
            shr:     res = a >> b[4:0];
            default: res = $signed(a) >>> b[4:0];
          endcase
          zero    = (res == '0);
          r[i.ra] = res;
        end
        op_ldi: r[i.ra] = imm;
        op_mul, op_mulh: begin
          prod    = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
          r[i.ra] = (i.opcode == op_mul) ? prod[31:0] : prod[63:32];
        end
        op_ldw: r[i.ra] = ref_mem[ea[11:2]];
        op_ldb: begin
          byte_val = ref_mem[ea[11:2]][8*ea[1:0] +: 8];
          r[i.ra]  = {{24{byte_val[7]}}, byte_val};
        end
        op_stw: begin
          exp_addr.push_back(ea);
          exp_lanes.push_back(4'b1111);
          exp_data.push_back(r[i.ra]);
          ref_mem[ea[11:2]] = r[i.ra];
        end
        op_stb: begin
          exp_addr.push_back(ea);
          exp_lanes.push_back(4'b0001 << ea[1:0]);
          exp_data.push_back({24'h0, r[i.ra][7:0]} << (8 * ea[1:0]));
          ref_mem[ea[11:2]][8*ea[1:0] +: 8] = r[i.ra][7:0];
        end
        op_bra: pc = pc + imm;
        op_beq: if (zero) pc = pc + imm;
        default: ;
      endcase
      r[0] = '0;
    end
  endtask

  task automatic run_test(int t, string name);
    int errors_before;
    int writes;
    errors_before = errors;
    test_name     = name;
    stall_en      = (t % 2 == 1);
    @(negedge clk);
    reset_n = 1'b0;
    build_program(t);
    foreach (mem[n]) mem[n] = (n >= 256 && n < 512) ? word_t'($urandom) : '0;
    foreach (prog[n]) mem[n] = prog[n];
    ref_mem = mem;
    exp_addr.delete();
    exp_lanes.delete();
    exp_data.delete();
    run_model();
    writes = exp_addr.size();
    repeat (8) @(negedge clk);
    reset_n = 1'b1;
    while (!halted) @(negedge clk);
    repeat (6) begin
      @(negedge clk);
      check_halt("halted", 1'b1, halted);
      if (read || write) begin
        $display("error %s: bus strobe seen after halt", test_name);
        errors++;
      end
    end
    if (exp_addr.size() != 0) begin
      $display("error %s: %0d predicted writes never came", test_name, exp_addr.size());
      errors++;
    end
    foreach (mem[n]) check_word($sformatf("memory word %0d", n), ref_mem[n], mem[n]);
    if (errors != errors_before)
      failed_tests++;
    $display("test %s: %0d writes, stalls %0d, %s", name, writes, stall_en,
             (errors == errors_before) ? "ok" : "failed");
  endtask

  initial begin
    string names [TESTS] = '{"alu_ops", "multiply", "stores", "byte_loads",
                             "branches", "stall_mix"};
    void'($urandom(32'hf274_13c6));
    reset_n     = 1'b0;
    waitrequest = 1'b1;
    readdata    = '0;
    stall_en    = 1'b0;
    for (int t = 0; t < TESTS; t++)
      run_test(t, names[t]);
    $display("tests %0d, failed %0d, errors %0d", TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+include
hdl/isa_pkg.sv
hdl/datapath_pkg.sv
hdl/alu.sv
hdl/intcalc.sv
hdl/register_file.sv
hdl/control.sv
hdl/bexkat_core.sv
tests/bexkat_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module bexkat_tb -f project.f -o sim_bexkat

out=$(./obj_dir/sim_bexkat)
echo "$out"

if echo "$out" | grep -q "^RESULT: PASS$"; then
  exit 0
else
  exit 1
fi
